//--- project.f
tluh_pkg.sv
tluh_beat_counter.sv
tluh_atomic_alu.sv
tluh_reg_file.sv
tluh_adapter_fsm.sv
tluh_reg_top.sv
tb_clock_gen.sv
tluh_reg_checker.sv
tluh_reg_tb.sv

//--- run.sh
#!/bin/sh
# build and run the register slave testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f project.f --top-module tluh_reg_tb -o tluh_reg_sim

./obj_dir/tluh_reg_sim > sim.log 2>&1 || true
cat sim.log

grep -qx "=== PASS ===" sim.log

//--- tluh_reg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tluh_reg_tb import tluh_pkg::*; ();

  // beats over all tests, used to size the watchdog
  localparam int TotalBeats = 88;
  localparam int RunCycles  = TotalBeats * 20 + 5;

  logic       clk;
  logic       rst_n;
  logic       d_rdy;
  tluh_h2d_t  a_drv;
  tluh_h2d_t  tl_h2d;
  tluh_d2h_t  tl_d2h;
  tluh_hint_t hint_o;

  logic [31:0] mirror [32];
  tluh_d2h_t   rsp_q [$];
  int          hint_cnt;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  always_comb begin
    tl_h2d         = a_drv;
    tl_h2d.d_ready = d_rdy;
  end

  tluh_reg_top #(.RegAw(8), .NumRegs(32)) UUT (
    .clk_i(clk), .rst_ni(rst_n), .tl_i(tl_h2d), .tl_o(tl_d2h), .hint_o(hint_o)
  );

  bind tluh_reg_top tluh_reg_checker u_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .tl_i(tl_i), .tl_o(tl_o)
  );

  //////////////////////////////
  // reference rules
  //////////////////////////////

  function automatic int beats_of(input logic [2:0] size);
    case (size)
      3'd3:    return 2;
      3'd4:    return 4;
      3'd5:    return 8;
      default: return 1;
    endcase
  endfunction

  // byte address of beat i, wraps at 256
  function automatic logic [7:0] beat_addr(input logic [31:0] addr, input int i);
    return {addr[7:2], 2'b00} + 8'(4 * i);
  endfunction

  function automatic logic beat_err(input logic [31:0] addr, input logic [7:0] a);
    return (addr[1:0] != 2'b00) || (a >= 8'h80);
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                        input logic [3:0] mask);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[8*b +: 8] = nw[8*b +: 8];
    end
    return res;
  endfunction

  // atomic function table
  function automatic logic [31:0] atomic_ref(input logic logical, input logic [2:0] param,
                                             input logic [31:0] op, input logic [31:0] old);
    if (logical) begin
      case (param)
        3'd0:    return op ^ old;
        3'd1:    return op | old;
        3'd2:    return op & old;
        3'd3:    return op;
        default: return old;
      endcase
    end
    case (param)
      3'd0:    return ($signed(op) < $signed(old)) ? op : old;
      3'd1:    return ($signed(op) > $signed(old)) ? op : old;
      3'd2:    return (op < old) ? op : old;
      3'd3:    return (op > old) ? op : old;
      3'd4:    return op + old;
      default: return old;
    endcase
  endfunction

  //////////////////////////////
  // checks and bus tasks
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  // d_param and d_sink are zero for every response this slave sends
  task automatic check_rsp(input tluh_d2h_t r, input tluh_d_op_e op, input logic [2:0] size,
                           input logic [7:0] src, input logic err);
    check_val("d_opcode", 32'(r.d_opcode), 32'(op));
    check_val("d_param", 32'(r.d_param), 32'h0);
    check_val("d_size", 32'(r.d_size), 32'(size));
    check_val("d_source", 32'(r.d_source), 32'(src));
    check_val("d_sink", 32'(r.d_sink), 32'h0);
    check_val("d_error", 32'(r.d_error), 32'(err));
  endtask

  // one A beat, returns the hint seen in the accepting cycle
  task automatic send_beat(input tluh_a_op_e op, input logic [2:0] param, input logic [2:0] size,
                           input logic [7:0] src, input logic [31:0] addr, input logic [3:0] mask,
                           input logic [31:0] data, output tluh_hint_t hint);
    @(negedge clk);
    a_drv.a_valid   = 1'b1;
    a_drv.a_opcode  = op;
    a_drv.a_param   = param;
    a_drv.a_size    = size;
    a_drv.a_source  = src;
    a_drv.a_address = addr;
    a_drv.a_mask    = mask;
    a_drv.a_data    = data;
    #1;
    while (!tl_d2h.a_ready) begin
      @(negedge clk);
      #1;
    end
    hint = hint_o;
    @(negedge clk);
    a_drv.a_valid = 1'b0;
  endtask

  task automatic wait_rsp(input int n);
    while (rsp_q.size() < n) @(negedge clk);
  endtask

  task automatic end_test(input string name);
    repeat (4) @(negedge clk);
    assert (rsp_q.size() == 0) else begin
      $display("test %s: DUT sent %0d extra D responses", name, rsp_q.size());
      test_errs++;
      rsp_q.delete();
    end
    tests_run++;
    if (test_errs != 0) tests_failed++;
    total_errs += test_errs;
    $display("test %-22s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed", test_errs);
    test_errs = 0;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic get_test(input string name, input logic [31:0] addr, input logic [2:0] size,
                          input logic [7:0] src);
    int         n;
    logic [7:0] a;
    logic       e;
    tluh_hint_t h;
    tluh_d2h_t  r;
    n = beats_of(size);
    send_beat(Get, 3'd0, size, src, addr, 4'hf, 32'h0, h);
    wait_rsp(n);
    for (int i = 0; i < n; i++) begin
      a = beat_addr(addr, i);
      e = beat_err(addr, a);
      r = rsp_q.pop_front();
      check_rsp(r, AccessAckData, size, src, e);
      check_val("d_data", r.d_data, e ? 32'h0 : mirror[a[6:2]]);
    end
    end_test(name);
  endtask

  task automatic put_test(input string name, input tluh_a_op_e op, input logic [31:0] addr,
                          input logic [2:0] size, input logic [7:0] src);
    logic [7:0]  a;
    logic        e;
    logic        err;
    logic [31:0] d;
    logic [3:0]  m;
    tluh_hint_t  h;
    tluh_d2h_t   r;
    err = 1'b0;
    for (int i = 0; i < beats_of(size); i++) begin
      a   = beat_addr(addr, i);
      e   = beat_err(addr, a);
      err = err | e;
      d   = $urandom;
      m   = (op == PutFullData) ? 4'hf : 4'($urandom);
      send_beat(op, 3'd0, size, src, addr, m, d, h);
      if (!e) mirror[a[6:2]] = merge(mirror[a[6:2]], d, m);
    end
    wait_rsp(1);
    r = rsp_q.pop_front();
    check_rsp(r, AccessAck, size, src, err);
    end_test(name);
  endtask

  task automatic atomic_test(input string name, input logic logical, input logic [2:0] param,
                             input logic [31:0] addr, input logic [2:0] size,
                             input logic [7:0] src);
    logic [7:0]  a;
    logic        e;
    logic [31:0] d;
    logic [31:0] old;
    tluh_hint_t  h;
    tluh_d2h_t   r;
    for (int i = 0; i < beats_of(size); i++) begin
      a   = beat_addr(addr, i);
      e   = beat_err(addr, a);
      d   = $urandom;
      old = e ? 32'h0 : mirror[a[6:2]];
      send_beat(logical ? LogicalData : ArithmeticData, param, size, src, addr, 4'hf, d, h);
      wait_rsp(1);
      r = rsp_q.pop_front();
      check_rsp(r, AccessAckData, size, src, e);
      check_val("d_data", r.d_data, old);
      if (!e) mirror[a[6:2]] = atomic_ref(logical, param, d, old);
    end
    end_test(name);
  endtask

  task automatic intent_test(input string name, input logic write, input logic [31:0] addr,
                             input logic [2:0] size, input logic [7:0] src);
    int         cnt0;
    logic       mis;
    tluh_hint_t h;
    tluh_d2h_t  r;
    cnt0 = hint_cnt;
    mis  = addr[1:0] != 2'b00;
    send_beat(Intent, {2'b00, write}, size, src, addr, 4'hf, 32'h0, h);
    if (!mis) begin
      check_val("hint_o.valid", 32'(h.valid), 32'h1);
      check_val("hint_o.write", 32'(h.write), 32'(write));
      check_val("hint_o.blocks", 32'(h.blocks), 32'(beats_of(size)));
    end
    wait_rsp(1);
    r = rsp_q.pop_front();
    check_rsp(r, HintAck, size, src, mis);
    repeat (2) @(negedge clk);
    check_val("hint strobes", 32'(hint_cnt - cnt0), mis ? 32'h0 : 32'h1);
    end_test(name);
  endtask

  // random d_ready, D beat capture and hint count
  initial begin
    d_rdy    = 1'b0;
    hint_cnt = 0;
    forever begin
      @(negedge clk);
      d_rdy = ($urandom % 4) != 0;
      #1;
      if (tl_d2h.d_valid && d_rdy) rsp_q.push_back(tl_d2h);
      if (hint_o.valid) hint_cnt++;
    end
  end

  initial begin
    repeat (RunCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, DUT stopped responding", RunCycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'h0ff5044f));
    a_drv        = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < 32; i++) begin
      mirror[i] = 32'h0;
    end
    @(posedge rst_n);
    for (int k = 0; k < 4; k++) begin
      put_test($sformatf("fill %0d", k), PutFullData, 32'(k * 32), 3'd5, 8'(k));
    end
    get_test("get single", 32'h14, 3'd2, 8'h11);
    get_test("get burst", 32'h40, 3'd4, 8'h12);
    get_test("get wrap", 32'hf0, 3'd5, 8'h13);
    put_test("put partial burst", PutPartialData, 32'h30, 3'd3, 8'h21);
    put_test("put partial single", PutPartialData, 32'h08, 3'd2, 8'h22);
    get_test("get after put", 32'h30, 3'd3, 8'h23);
    // MIN .. ADD, then XOR .. SWAP
    for (int p = 0; p < 5; p++) begin
      atomic_test($sformatf("arith param %0d", p), 1'b0, 3'(p), 32'h50, 3'd3, 8'h31);
    end
    for (int p = 0; p < 4; p++) begin
      atomic_test($sformatf("logical param %0d", p), 1'b1, 3'(p), 32'h60, 3'd2, 8'h32);
    end
    get_test("get after atomics", 32'h48, 3'd5, 8'h33);
    intent_test("intent read", 1'b0, 32'h10, 3'd4, 8'h41);
    intent_test("intent write", 1'b1, 32'h20, 3'd5, 8'h42);
    get_test("get misaligned", 32'h22, 3'd2, 8'h51);
    put_test("put misaligned", PutFullData, 32'h06, 3'd3, 8'h52);
    put_test("put out of range", PutFullData, 32'h80, 3'd2, 8'h53);
    atomic_test("atomic out of range", 1'b0, 3'd4, 32'h9c, 3'd2, 8'h54);
    intent_test("intent misaligned", 1'b1, 32'h11, 3'd3, 8'h55);
    get_test("get unchanged", 32'h00, 3'd5, 8'h56);
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, total_errs);
    if (tests_failed == 0 && total_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tluh_reg_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tluh_reg_checker import tluh_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input tluh_h2d_t tl_i,
  input tluh_d2h_t tl_o
);

  // every D field the host may sample
  logic [3+3+TL_SZW+TL_AIW+1+TL_DW+1-1:0] d_fields;

  assign d_fields = {tl_o.d_opcode, tl_o.d_param, tl_o.d_size, tl_o.d_source,
                     tl_o.d_sink, tl_o.d_data, tl_o.d_error};

  //////////////////////////////
  // handshake rules
  //////////////////////////////

  // one request in flight
  a_ready_vs_d_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tl_o.d_valid |-> !tl_o.a_ready
  ) else $error("a_ready is high while d_valid is high");

  // stalled response must hold
  d_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (tl_o.d_valid && !tl_i.d_ready) |=> (tl_o.d_valid && $stable(d_fields))
  ) else $error("D channel changed while stalled by d_ready");

  reset_quiet: assert property (
    @(posedge clk_i)
    !rst_ni |-> (!tl_o.a_ready && !tl_o.d_valid)
  ) else $error("a_ready or d_valid high during reset");

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held for 5 cycles, released away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- tluh_reg_top.sv
`timescale 1ns/1ns
`default_nettype none

module tluh_reg_top import tluh_pkg::*; #(
  parameter int RegAw   = 8,
  parameter int NumRegs = 32
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  tluh_h2d_t  tl_i,
  output tluh_d2h_t  tl_o,
  output tluh_hint_t hint_o
);

  tluh_reg_req_t           reg_req;
  logic [TL_DW-1:0]        rdata;
  logic                    range_err;
  logic                    cnt_load;
  logic                    cnt_step;
  logic [TL_BEATSMAXW-1:0] cnt_beats;
  logic [RegAw-1:0]        cnt_start;
  logic [RegAw-1:0]        cur_addr;
  logic                    last;
  logic [TL_DW-1:0]        alu_operand;
  logic [TL_DW-1:0]        alu_stored;
  logic                    alu_logical;
  tluh_atomic_param_u      alu_param;
  logic [TL_DW-1:0]        alu_result;

  tluh_adapter_fsm #(.RegAw(RegAw)) u_adapter (
    .clk_i, .rst_ni, .tl_i, .tl_o, .hint_o,
    .reg_req_o     (reg_req),
    .rdata_i       (rdata),
    .range_err_i   (range_err),
    .cnt_load_o    (cnt_load),
    .cnt_step_o    (cnt_step),
    .cnt_beats_o   (cnt_beats),
    .cnt_start_o   (cnt_start),
    .cur_addr_i    (cur_addr),
    .last_i        (last),
    .alu_operand_o (alu_operand),
    .alu_stored_o  (alu_stored),
    .alu_logical_o (alu_logical),
    .alu_param_o   (alu_param),
    .alu_result_i  (alu_result)
  );

  tluh_beat_counter #(.RegAw(RegAw)) u_counter (
    .clk_i, .rst_ni,
    .load_i       (cnt_load),
    .step_i       (cnt_step),
    .start_addr_i (cnt_start),
    .beats_i      (cnt_beats),
    .cur_addr_o   (cur_addr),
    .last_o       (last)
  );

  tluh_atomic_alu u_alu (
    .operand_i (alu_operand),
    .stored_i  (alu_stored),
    .logical_i (alu_logical),
    .param_i   (alu_param),
    .result_o  (alu_result)
  );

  tluh_reg_file #(.RegAw(RegAw), .NumRegs(NumRegs)) u_regs (
    .clk_i, .rst_ni,
    .req_i       (reg_req),
    .rdata_o     (rdata),
    .range_err_o (range_err)
  );

endmodule

`default_nettype wire

//--- tluh_adapter_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module tluh_adapter_fsm import tluh_pkg::*; #(
  parameter int RegAw = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tluh_h2d_t               tl_i,
  output tluh_d2h_t               tl_o,
  output tluh_hint_t              hint_o,
  output tluh_reg_req_t           reg_req_o,
  input  logic [TL_DW-1:0]        rdata_i,
  input  logic                    range_err_i,
  output logic                    cnt_load_o,
  output logic                    cnt_step_o,
  output logic [TL_BEATSMAXW-1:0] cnt_beats_o,
  output logic [RegAw-1:0]        cnt_start_o,
  input  logic [RegAw-1:0]        cur_addr_i,
  input  logic                    last_i,
  output logic [TL_DW-1:0]        alu_operand_o,
  output logic [TL_DW-1:0]        alu_stored_o,
  output logic                    alu_logical_o,
  output tluh_atomic_param_u      alu_param_o,
  input  logic [TL_DW-1:0]        alu_result_i
);

  typedef enum logic [2:0] {
    IDLE, READ_BEAT, WRITE_BEAT, ATOMIC_WRITE, ATOMIC_NEXT, RESPOND
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  logic                    a_ack;
  logic                    d_ack;
  logic                    is_get;
  logic                    is_put;
  logic                    is_atomic;
  logic                    is_intent;
  logic                    misalign;
  logic                    req_err;
  logic                    start;
  logic                    re;
  logic                    we;
  logic [TL_BEATSMAXW-1:0] beats;
  logic [RegAw-1:0]        word_addr;
  logic [RegAw-1:0]        access_addr;
  logic                    a_ready_q;
  logic                    d_valid_q;
  logic                    err_q;
  logic                    last_q;
  logic                    d_error_q;
  tluh_d_op_e              rsp_op_q;
  logic [TL_SZW-1:0]       size_q;
  logic [TL_AIW-1:0]       source_q;
  logic [TL_DW-1:0]        d_data_q;
  logic [TL_DW-1:0]        operand_q;
  logic [TL_DBW-1:0]       mask_q;
  logic [RegAw-1:0]        addr_q;
  logic                    logical_q;
  tluh_atomic_param_u      param_q;

  assign a_ack = tl_i.a_valid & a_ready_q;
  assign d_ack = d_valid_q & tl_i.d_ready;
  assign start = a_ack & (state_q == IDLE);

  //////////////////////////////
  // request decode
  //////////////////////////////

  assign is_get    = tl_i.a_opcode == Get;
  assign is_put    = (tl_i.a_opcode == PutFullData) | (tl_i.a_opcode == PutPartialData);
  assign is_atomic = (tl_i.a_opcode == ArithmeticData) | (tl_i.a_opcode == LogicalData);
  assign is_intent = tl_i.a_opcode == Intent;
  assign misalign  = |tl_i.a_address[1:0];
  assign word_addr = {tl_i.a_address[RegAw-1:2], 2'b00};
  assign req_err   = (state_q == IDLE) ? misalign : err_q;

  // 2^size / 4 beats, at least one
  always_comb begin
    case (tl_i.a_size)
      TL_SZW'(3): beats = TL_BEATSMAXW'(2);
      TL_SZW'(4): beats = TL_BEATSMAXW'(4);
      TL_SZW'(5): beats = TL_BEATSMAXW'(8);
      default:    beats = TL_BEATSMAXW'(1);
    endcase
  end

  // atomic write goes back to the word read one cycle earlier
  always_comb begin
    case (state_q)
      IDLE:         access_addr = word_addr;
      ATOMIC_WRITE: access_addr = addr_q;
      default:      access_addr = cur_addr_i;
    endcase
  end

  always_comb begin
    re = 1'b0;
    we = 1'b0;
    case (state_q)
      IDLE: begin
        re = a_ack & (is_get | is_atomic);
        we = a_ack & is_put;
      end
      READ_BEAT:    re = d_ack & ~last_q;
      WRITE_BEAT:   we = a_ack;
      ATOMIC_WRITE: we = 1'b1;
      ATOMIC_NEXT:  re = a_ack;
      default: ;
    endcase
    // misaligned request touches nothing
    if (req_err) begin
      re = 1'b0;
      we = 1'b0;
    end
  end

  assign reg_req_o = '{
    re:    re,
    we:    we,
    addr:  TL_AW'(access_addr),
    wdata: (state_q == ATOMIC_WRITE) ? alu_result_i : tl_i.a_data,
    be:    (state_q == ATOMIC_WRITE) ? mask_q : tl_i.a_mask
  };

  assign cnt_load_o  = start;
  assign cnt_beats_o = beats;
  assign cnt_start_o = word_addr;
  assign cnt_step_o  = ((state_q == READ_BEAT) & d_ack & ~last_q) |
                       (((state_q == WRITE_BEAT) | (state_q == ATOMIC_NEXT)) & a_ack);

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (a_ack) begin
          if (is_get) begin
            state_d = READ_BEAT;
          end else if (is_atomic) begin
            state_d = ATOMIC_WRITE;
          end else if (is_put && beats != TL_BEATSMAXW'(1)) begin
            state_d = WRITE_BEAT;
          end else begin
            state_d = RESPOND;
          end
        end
      end
      READ_BEAT: if (d_ack && last_q) state_d = IDLE;
      WRITE_BEAT: if (a_ack && last_i) state_d = RESPOND;
      ATOMIC_NEXT: if (a_ack) state_d = ATOMIC_WRITE;
      ATOMIC_WRITE, RESPOND: begin
        if (d_ack) begin
          // only an atomic burst answers with data from here
          state_d = (rsp_op_q == AccessAckData && !last_q) ? ATOMIC_NEXT : IDLE;
        end else begin
          state_d = RESPOND;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      a_ready_q <= 1'b0;
      d_valid_q <= 1'b0;
      err_q     <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      a_ready_q <= state_d inside {IDLE, WRITE_BEAT, ATOMIC_NEXT};
      d_valid_q <= state_d inside {READ_BEAT, ATOMIC_WRITE, RESPOND};
      if (start) begin
        err_q  <= misalign;
        last_q <= beats == TL_BEATSMAXW'(1);
      end else if (cnt_step_o) begin
        last_q <= last_i;
      end
    end
  end

  //////////////////////////////
  // response and operands
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (start) begin
      source_q  <= tl_i.a_source;
      size_q    <= tl_i.a_size;
      rsp_op_q  <= (is_get | is_atomic) ? AccessAckData : (is_intent ? HintAck : AccessAck);
      d_data_q  <= rdata_i;
      // unknown opcodes are answered with an error
      d_error_q <= misalign | ((is_get | is_put | is_atomic) & range_err_i) |
                   ~(is_get | is_put | is_atomic | is_intent);
    end else if (state_q == WRITE_BEAT && a_ack) begin
      d_error_q <= d_error_q | range_err_i;
    end else if (cnt_step_o) begin
      d_data_q  <= rdata_i;
      d_error_q <= err_q | range_err_i;
    end
    if (a_ack) begin
      operand_q <= tl_i.a_data;
      mask_q    <= tl_i.a_mask;
      addr_q    <= access_addr;
      logical_q <= tl_i.a_opcode[0];
      param_q   <= tluh_atomic_param_u'(tl_i.a_param);
    end
  end

  assign alu_operand_o = operand_q;
  assign alu_stored_o  = d_data_q;
  assign alu_logical_o = logical_q;
  assign alu_param_o   = param_q;

  assign hint_o = '{
    valid:  start & is_intent & ~misalign,
    write:  tl_i.a_param[0],
    blocks: beats
  };

  assign tl_o = '{
    a_ready:  a_ready_q,
    d_valid:  d_valid_q,
    d_opcode: rsp_op_q,
    d_param:  '0,
    d_size:   size_q,
    d_source: source_q,
    d_sink:   1'b0,
    d_data:   d_data_q,
    d_error:  d_error_q
  };

endmodule

`default_nettype wire

//--- tluh_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module tluh_reg_file import tluh_pkg::*; #(
  parameter int RegAw   = 8,
  parameter int NumRegs = 32
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  tluh_reg_req_t    req_i,
  output logic [TL_DW-1:0] rdata_o,
  output logic             range_err_o
);

  localparam int IdxW = $clog2(NumRegs);

  logic [TL_DW-1:0] regs_q [NumRegs];
  logic [IdxW-1:0]  idx;

  assign idx = req_i.addr[2 +: IdxW];

  // past the last word, or outside the register window
  assign range_err_o = (req_i.addr[RegAw-1:0] >= RegAw'(NumRegs * TL_DBW)) |
                       (|req_i.addr[TL_AW-1:RegAw]);

  assign rdata_o = (req_i.re && !range_err_o) ? regs_q[idx] : '0;

  //////////////////////////////
  // byte-enabled write
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (req_i.we && !range_err_o) begin
      for (int b = 0; b < TL_DBW; b++) begin
        if (req_i.be[b]) begin
          regs_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tluh_atomic_alu.sv
`timescale 1ns/1ns
`default_nettype none

module tluh_atomic_alu import tluh_pkg::*; (
  input  logic [TL_DW-1:0]  operand_i,
  input  logic [TL_DW-1:0]  stored_i,
  input  logic              logical_i,
  input  tluh_atomic_param_u param_i,
  output logic [TL_DW-1:0]  result_o
);

  logic signed_lt;
  logic unsigned_lt;

  // operand compared against the stored word
  assign signed_lt   = $signed(operand_i) < $signed(stored_i);
  assign unsigned_lt = operand_i < stored_i;

  always_comb begin
    result_o = stored_i;
    if (logical_i) begin
      case (param_i.logical)
        XOR:     result_o = operand_i ^ stored_i;
        OR:      result_o = operand_i | stored_i;
        AND:     result_o = operand_i & stored_i;
        SWAP:    result_o = operand_i;
        // reserved codes leave the word alone
        default: result_o = stored_i;
      endcase
    end else begin
      case (param_i.arith)
        MIN:     result_o = signed_lt ? operand_i : stored_i;
        MAX:     result_o = signed_lt ? stored_i : operand_i;
        MINU:    result_o = unsigned_lt ? operand_i : stored_i;
        MAXU:    result_o = unsigned_lt ? stored_i : operand_i;
        // no carry in from the previous beat
        ADD:     result_o = operand_i + stored_i;
        default: result_o = stored_i;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tluh_beat_counter.sv
`timescale 1ns/1ns
`default_nettype none

module tluh_beat_counter import tluh_pkg::*; #(
  parameter int RegAw = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_i,
  input  logic                    step_i,
  input  logic [RegAw-1:0]        start_addr_i,
  input  logic [TL_BEATSMAXW-1:0] beats_i,
  output logic [RegAw-1:0]        cur_addr_o,
  output logic                    last_o
);

  // beats still to issue, and the address of the next one
  logic [TL_BEATSMAXW-1:0] left_q;
  logic [RegAw-1:0]        addr_q;

  // first beat is issued by the adapter at load time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      left_q <= '0;
      addr_q <= '0;
    end else if (load_i) begin
      left_q <= beats_i - TL_BEATSMAXW'(1);
      addr_q <= start_addr_i + RegAw'(TL_DBW);
    end else if (step_i && left_q != '0) begin
      left_q <= left_q - TL_BEATSMAXW'(1);
      // wraps at 2^RegAw by width
      addr_q <= addr_q + RegAw'(TL_DBW);
    end
  end

  assign cur_addr_o = addr_q;

  // next beat issued is the final one
  assign last_o = (left_q == TL_BEATSMAXW'(1));

endmodule

`default_nettype wire

//--- tluh_pkg.sv
`default_nettype none

package tluh_pkg;

  //////////////////////////////
  // bus geometry
  //////////////////////////////

  parameter int TL_DW        = 32;
  parameter int TL_DBW       = TL_DW / 8;
  parameter int TL_AW        = 32;
  parameter int TL_SZW       = 3;
  parameter int TL_AIW       = 8;
  // enough for an 8-beat burst (size 5)
  parameter int TL_BEATSMAXW = 4;

  //////////////////////////////
  // opcodes
  //////////////////////////////

  // bit 0 tells the two atomic kinds apart
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    LogicalData    = 3'h3,
    Get            = 3'h4,
    Intent         = 3'h5
  } tluh_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1,
    HintAck       = 3'h2
  } tluh_d_op_e;

  // a_param of ArithmeticData
  typedef enum logic [2:0] {
    MIN  = 3'h0,
    MAX  = 3'h1,
    MINU = 3'h2,
    MAXU = 3'h3,
    ADD  = 3'h4
  } tluh_arith_e;

  // a_param of LogicalData
  typedef enum logic [2:0] {
    XOR  = 3'h0,
    OR   = 3'h1,
    AND  = 3'h2,
    SWAP = 3'h3
  } tluh_logic_e;

  // same param bits, read by opcode kind
  typedef union packed {
    tluh_arith_e arith;
    tluh_logic_e logical;
  } tluh_atomic_param_u;

  //////////////////////////////
  // channels
  //////////////////////////////

  typedef struct packed {
    logic                  a_valid;
    tluh_a_op_e            a_opcode;
    logic [2:0]            a_param;
    logic [TL_SZW-1:0]     a_size;
    logic [TL_AIW-1:0]     a_source;
    logic [TL_AW-1:0]      a_address;
    logic [TL_DBW-1:0]     a_mask;
    logic [TL_DW-1:0]      a_data;
    logic                  d_ready;
  } tluh_h2d_t;

  typedef struct packed {
    logic                  a_ready;
    logic                  d_valid;
    tluh_d_op_e            d_opcode;
    logic [2:0]            d_param;
    logic [TL_SZW-1:0]     d_size;
    logic [TL_AIW-1:0]     d_source;
    logic                  d_sink;
    logic [TL_DW-1:0]      d_data;
    logic                  d_error;
  } tluh_d2h_t;

  // adapter to register file
  typedef struct packed {
    logic                  re;
    logic                  we;
    logic [TL_AW-1:0]      addr;
    logic [TL_DW-1:0]      wdata;
    logic [TL_DBW-1:0]     be;
  } tluh_reg_req_t;

  // prefetch hint, write = 1 for a prefetch write
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [TL_BEATSMAXW-1:0] blocks;
  } tluh_hint_t;

endpackage

`default_nettype wire
